/* Bender.yml */
package:
  name: xwys_mult

export_include_dirs:
  - logic

sources:
  # RTL
  - include_dirs:
      - logic
    files:
      - logic/xwys_mult_pkg.sv
      - logic/pp_gen_stage.sv
      - logic/approx_compress_stage.sv
      - logic/final_sum_stage.sv
      - logic/xwys_mult_top.sv

  # Testbench and bound assertions
  - target: test
    include_dirs:
      - logic
    files:
      - test/xwys_mult_properties.sv
      - test/xwys_mult_tb.sv

/* logic/approx_compress_stage.sv */
`timescale 1ns/1ps

`include "xwys_mult_cfg.svh"

module approx_compress_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  xwys_mult_pkg::pp_array_t   rows,
    input  logic                       approx,
    input  logic                       valid,
    output xwys_mult_pkg::pp_array_t   upper_rows,
    output xwys_mult_pkg::pp_array_t   low_rows,
    output xwys_mult_pkg::corr_array_t corr,
    output logic                       approx_q,
    output logic                       valid_q
);

    import xwys_mult_pkg::*;

    localparam int ROWS = `XWYS_ROWS;
    localparam int LOW  = `XWYS_LOW_ROWS;

    pp_array_t   upper_d;
    pp_array_t   low_d;
    corr_array_t corr_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Row split
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        upper_d = rows;
        low_d   = rows;
        for (int k = 0; k < ROWS; k++) begin
            if (k < LOW) begin
                upper_d[k] = '0;
            end else begin
                low_d[k] = '0;
            end
        end
        if (approx) begin
            low_d = '0;  // Replaced by corr
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Correction words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Pairs of neighbouring low rows at fixed product bits
    always_comb begin
        corr_d = '0;
        if (approx) begin
            // Word 0
            corr_d[0][3]  = rows[0][2]  & rows[1][1];
            corr_d[0][5]  = rows[4][1]  ^ rows[5][0];
            corr_d[0][7]  = rows[0][7]  ^ rows[1][6];
            corr_d[0][9]  = rows[2][6]  & rows[3][5];
            corr_d[0][10] = rows[2][7]  & rows[3][6];
            corr_d[0][11] = rows[2][9]  ^ rows[3][8];
            corr_d[0][13] = rows[0][13] ^ rows[1][12];
            corr_d[0][14] = rows[2][11] & rows[3][10];
            corr_d[0][15] = rows[4][10] & rows[5][9];
            corr_d[0][16] = 1'b1;  // Row 1 sign OR'd with 1
            corr_d[0][17] = rows[1][15];
            corr_d[0][18] = rows[2][15] & rows[3][14];
            corr_d[0][19] = rows[4][14] & rows[5][13];
            corr_d[0][20] = rows[4][15] & rows[5][14];

            // Word 1
            corr_d[1][7]  = rows[2][4]  & rows[3][3];
            corr_d[1][10] = rows[4][5]  & rows[5][4];
            corr_d[1][11] = rows[4][7]  ^ rows[5][6];
            corr_d[1][13] = rows[2][10] & rows[3][9];
            corr_d[1][14] = rows[4][10] ^ rows[5][9];
            corr_d[1][16] = rows[2][14] ^ rows[3][13];
            corr_d[1][17] = rows[2][15] ^ rows[3][14];
            corr_d[1][18] = rows[3][15];
            corr_d[1][19] = rows[4][15] ^ rows[5][14];
            corr_d[1][20] = rows[5][15];

            // Word 2, half adder on bit 17
            corr_d[2][17] = rows[4][13] ^ rows[5][12];
            corr_d[2][18] = rows[4][13] & rows[5][12];

            // Word 3
            corr_d[3][18] = rows[4][14] ^ rows[5][13];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 2 registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            upper_rows <= '0;
            low_rows   <= '0;
            corr       <= '0;
            approx_q   <= 1'b0;
        end else if (valid) begin
            upper_rows <= upper_d;
            low_rows   <= low_d;
            corr       <= corr_d;
            approx_q   <= approx;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid;
        end
    end

endmodule

/* logic/final_sum_stage.sv */
`timescale 1ns/1ps

`include "xwys_mult_cfg.svh"

module final_sum_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  xwys_mult_pkg::pp_array_t    upper_rows,
    input  xwys_mult_pkg::pp_array_t    low_rows,
    input  xwys_mult_pkg::corr_array_t  corr,
    input  logic                        valid,
    output logic [2*`XWYS_WIDTH-1:0]    z,
    output logic                        out_valid
);

    import xwys_mult_pkg::*;

    localparam int ZW     = 2 * `XWYS_WIDTH;
    localparam int ROWS   = `XWYS_ROWS;
    localparam int LOW    = `XWYS_LOW_ROWS;
    localparam int NCORR  = `XWYS_CORR_WORDS;
    localparam int ROW_W  = $bits(pp_row_t);
    localparam int CORR_W = $bits(corr_word_t);

    logic [ZW-1:0] sum;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Adder tree
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Each row sits at its x-bit weight, carries out of bit 31 dropped
    always_comb begin
        sum = '0;
        for (int k = 0; k < LOW; k++) begin
            sum = sum + ({{(ZW-ROW_W){1'b0}}, low_rows[k]} << k);
        end
        for (int k = LOW; k < ROWS; k++) begin
            sum = sum + ({{(ZW-ROW_W){1'b0}}, upper_rows[k]} << k);
        end
        for (int c = 0; c < NCORR; c++) begin
            sum = sum + {{(ZW-CORR_W){1'b0}}, corr[c]};  // Unshifted
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            z <= '0;
        end else if (valid) begin
            z <= sum;  // Holds while no result is due
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid;
        end
    end

endmodule

/* logic/pp_gen_stage.sv */
`timescale 1ns/1ps

`include "xwys_mult_cfg.svh"

module pp_gen_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`XWYS_WIDTH-1:0]  x,
    input  logic [`XWYS_WIDTH-1:0]  y,
    input  logic                    approx,
    input  logic                    in_valid,
    output xwys_mult_pkg::pp_array_t rows,
    output logic                    approx_q,
    output logic                    valid_q
);

    import xwys_mult_pkg::*;

    localparam int W    = `XWYS_WIDTH;
    localparam int ROWS = `XWYS_ROWS;

    pp_array_t row_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Row generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int k = 0; k < ROWS; k++) begin
            row_d[k]          = '0;
            row_d[k][W-2:0]   = y[W-2:0] & {(W-1){x[k]}};
            row_d[k][W-1]     = ~(y[W-1] & x[k]);  // Sign product inverted
        end

        // Constant 1 at bit 16 of the product
        row_d[0][W] = 1'b1;

        // Last row has the inversion reversed
        row_d[ROWS-1][W-2:0] = ~(y[W-2:0] & {(W-1){x[ROWS-1]}});
        row_d[ROWS-1][W-1]   = y[W-1] & x[ROWS-1];
        row_d[ROWS-1][W]     = 1'b1;  // Lands on bit 31
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1 registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rows     <= '0;
            approx_q <= 1'b0;
        end else if (in_valid) begin  // Hold rows between operands
            rows     <= row_d;
            approx_q <= approx;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

endmodule

/* logic/xwys_mult_cfg.svh */
`ifndef XWYS_MULT_CFG_SVH
`define XWYS_MULT_CFG_SVH

// Operand and row geometry
`define XWYS_WIDTH       16
`define XWYS_ROWS        16
`define XWYS_ROW_WIDTH   17  // 16 bits plus constant-1 slot
`define XWYS_LOW_ROWS    6   // Rows replaced in approximate mode

// Sparse correction words
`define XWYS_CORR_WIDTH  21
`define XWYS_CORR_WORDS  4

`define XWYS_LATENCY     3   // in_valid to out_valid, in cycles

`endif

/* logic/xwys_mult_pkg.sv */
`include "xwys_mult_cfg.svh"

package xwys_mult_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Partial products
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One Baugh-Wooley row, bit 16 only used by first and last rows
    typedef logic [`XWYS_ROW_WIDTH-1:0] pp_row_t;

    // Index is the x bit the row belongs to
    typedef pp_row_t [`XWYS_ROWS-1:0] pp_array_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Low-row correction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Unshifted, added at bit 0
    typedef logic [`XWYS_CORR_WIDTH-1:0] corr_word_t;

    typedef corr_word_t [`XWYS_CORR_WORDS-1:0] corr_array_t;

endpackage

/* logic/xwys_mult_top.sv */
`timescale 1ns/1ps

`include "xwys_mult_cfg.svh"

module xwys_mult_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic signed [`XWYS_WIDTH-1:0]   x,
    input  logic signed [`XWYS_WIDTH-1:0]   y,
    input  logic                            approx,
    input  logic                            in_valid,
    output logic signed [2*`XWYS_WIDTH-1:0] z,
    output logic                            out_valid
);

    xwys_mult_pkg::pp_array_t   rows_s1;
    logic                       approx_s1;
    logic                       valid_s1;
    xwys_mult_pkg::pp_array_t   upper_s2;
    xwys_mult_pkg::pp_array_t   low_s2;
    xwys_mult_pkg::corr_array_t corr_s2;
    logic                       valid_s2;

    pp_gen_stage pp_gen_stage_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .x        (x),
        .y        (y),
        .approx   (approx),
        .in_valid (in_valid),
        .rows     (rows_s1),
        .approx_q (approx_s1),
        .valid_q  (valid_s1)
    );

    approx_compress_stage approx_compress_stage_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .rows       (rows_s1),
        .approx     (approx_s1),
        .valid      (valid_s1),
        .upper_rows (upper_s2),
        .low_rows   (low_s2),
        .corr       (corr_s2),
        .approx_q   (),          // Final sum ignores the mode
        .valid_q    (valid_s2)
    );

    final_sum_stage final_sum_stage_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .upper_rows (upper_s2),
        .low_rows   (low_s2),
        .corr       (corr_s2),
        .valid      (valid_s2),
        .z          (z),
        .out_valid  (out_valid)
    );

endmodule

/* test/xwys_mult_properties.sv */
`timescale 1ns/1ps

`include "xwys_mult_cfg.svh"

module xwys_mult_properties (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     in_valid,
    input logic                     out_valid,
    input logic [2*`XWYS_WIDTH-1:0] z
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Valid pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    latency_a: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> ##`XWYS_LATENCY out_valid)
        else $error("out_valid missing %0d cycles after in_valid", `XWYS_LATENCY);

    // No result without a matching input
    origin_a: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(in_valid, `XWYS_LATENCY))
        else $error("out_valid without in_valid %0d cycles earlier", `XWYS_LATENCY);

    reset_a: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output hold
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        !out_valid |-> $stable(z))
        else $error("z changed while out_valid low");

endmodule

bind xwys_mult_top xwys_mult_properties xwys_mult_properties_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .z         (z)
);

/* test/xwys_mult_tb.sv */
`timescale 1ns/1ps

`include "xwys_mult_cfg.svh"

module xwys_mult_tb;

    localparam int W       = `XWYS_WIDTH;
    localparam int ZW      = 2 * `XWYS_WIDTH;
    localparam int TIMEOUT = 100;  // Cycles allowed for any one wait
    localparam int MAX_VEC = 64;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic signed [W-1:0]  x;
    logic signed [W-1:0]  y;
    logic                 approx;
    logic                 in_valid;
    logic signed [ZW-1:0] z;
    logic                 out_valid;

    logic [ZW-1:0] exp_q[$];  // Expected results in flight
    logic [ZW-1:0] last_z;
    logic [ZW-1:0] last_exp;
    logic [W-1:0]  vec_x [MAX_VEC];
    logic [W-1:0]  vec_y [MAX_VEC];
    logic          vec_m [MAX_VEC];
    logic [ZW-1:0] vec_z [MAX_VEC];
    int            approx_idx[$];
    int            n_vec;
    int            errors;
    int            checks;
    int            tests_run;
    int            received;
    integer        seed;
    bit            timed_out;

    xwys_mult_top xwys_mult_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .x         (x),
        .y         (y),
        .approx    (approx),
        .in_valid  (in_valid),
        .z         (z),
        .out_valid (out_valid)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [ZW-1:0] got,
                               input logic [ZW-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, expected);
        end
    endtask

    function automatic logic [ZW-1:0] signed_product(input logic [W-1:0] a,
                                                     input logic [W-1:0] b);
        logic signed [ZW-1:0] pa;
        logic signed [ZW-1:0] pb;
        pa = $signed(a);
        pb = $signed(b);
        return pa * pb;
    endfunction

    // Drives one pair for one cycle
    // Caller drops in_valid afterwards
    task automatic send_pair(input logic [W-1:0] a, input logic [W-1:0] b,
                             input logic mode, input logic [ZW-1:0] expected);
        x        = a;
        y        = b;
        approx   = mode;
        in_valid = 1'b1;
        exp_q.push_back(expected);
        last_exp = expected;
        @(negedge clk);
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            timed_out = 1'b1;
            $display("Timeout in %s: %0d results never came out", what, exp_q.size());
        end
        @(negedge clk);  // Let the last out_valid pulse drop
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        $display("test %s %0d errors", name, errors - err0);
    endtask

    task automatic load_vectors();
        int            fd;
        int            r;
        string         line;
        logic [W-1:0]  a;
        logic [W-1:0]  b;
        logic [3:0]    m;
        logic [ZW-1:0] e;
        fd = $fopen("test/xwys_mult_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open test/xwys_mult_tests.txt");
            return;
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            r = $fgets(line, fd);
            if (r > 0 && $sscanf(line, "%h %h %h %h", a, b, m, e) == 4) begin
                vec_x[n_vec] = a;
                vec_y[n_vec] = b;
                vec_m[n_vec] = m[0];
                vec_z[n_vec] = e;
                if (m[0]) approx_idx.push_back(n_vec);
                n_vec++;
            end
        end
        $fclose(fd);
        if (approx_idx.size() == 0) begin
            errors++;
            $display("No approximate-mode vectors found in the data file");
        end
    endtask

    task automatic measure_latency(input logic [W-1:0] a, input logic [W-1:0] b);
        int lat;
        send_pair(a, b, 1'b0, signed_product(a, b));
        in_valid = 1'b0;
        lat      = 1;  // Sampling edge already behind us
        while (!out_valid && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
        end
        if (!out_valid) begin
            timed_out = 1'b1;
            $display("Timeout: no out_valid within %0d cycles of an isolated pair", TIMEOUT);
        end else begin
            check_value("latency", lat, `XWYS_LATENCY);
        end
        wait_drain("latency");
    endtask

    // Scoreboard on the falling edge
    always @(negedge clk) begin
        logic [ZW-1:0] exp_z;
        if (arst_n && out_valid) begin
            received++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_valid pulsed at %0t ns with no operand pair in flight", $time);
            end else begin
                exp_z  = exp_q.pop_front();
                check_value("z", z, exp_z);
                last_z = exp_z;
            end
        end else if (arst_n) begin
            check_value("z", z, last_z);  // Held between results
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int           err0;
        int           rx0;
        int           k;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] corner [5];

        seed      = 32'h311e;
        arst_n    = 1'b0;
        x         = '0;
        y         = '0;
        approx    = 1'b0;
        in_valid  = 1'b0;
        last_z    = '0;
        last_exp  = '0;
        n_vec     = 0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        received  = 0;
        timed_out = 1'b0;
        corner    = '{16'h0000, 16'h0001, 16'hffff, 16'h8000, 16'h7fff};
        load_vectors();

        err0 = errors;
        repeat (10) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
        end
        arst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);  // One cycle after release
        end_test("reset", err0);

        err0 = errors;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                send_pair(corner[i], corner[j], 1'b0, signed_product(corner[i], corner[j]));
            end
        end
        repeat (200) begin
            a = $random(seed);
            b = $random(seed);
            send_pair(a, b, 1'b0, signed_product(a, b));
        end
        in_valid = 1'b0;
        wait_drain("exact");
        end_test("exact", err0);

        if (!timed_out) begin
            err0 = errors;
            for (int i = 0; i < n_vec; i++) begin
                send_pair(vec_x[i], vec_y[i], vec_m[i], vec_z[i]);
            end
            in_valid = 1'b0;
            wait_drain("vectors");
            end_test("approx", err0);
        end

        if (!timed_out) begin
            err0 = errors;
            for (int i = 0; i < 4 && !timed_out; i++) begin
                a = $random(seed);
                b = $random(seed);
                measure_latency(a, b);
            end
            end_test("latency", err0);
        end

        if (!timed_out && approx_idx.size() != 0) begin
            err0 = errors;
            rx0  = received;
            for (int i = 0; i < 32; i++) begin
                if (i % 2 == 0) begin
                    a = $random(seed);
                    b = $random(seed);
                    send_pair(a, b, 1'b0, signed_product(a, b));
                end else begin
                    k = approx_idx[(i / 2) % approx_idx.size()];
                    send_pair(vec_x[k], vec_y[k], 1'b1, vec_z[k]);
                end
            end
            in_valid = 1'b0;
            wait_drain("streaming");
            check_value("result_count", received - rx0, 32);
            end_test("streaming", err0);
        end

        if (!timed_out) begin
            err0 = errors;
            repeat (8) @(negedge clk);  // Gap with no in_valid
            check_value("z", z, last_exp);
            send_pair(16'h0040, 16'h0064, 1'b0, signed_product(16'h0040, 16'h0064));
            in_valid = 1'b0;
            wait_drain("hold");
            end_test("hold", err0);
        end

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* test/xwys_mult_tests.txt */
# x    y    approx  expected_z   (all fields hex)
# approx=1 drops rows 0 to 5 and adds the four correction words
0040 0064 1 00009900
7fc0 7fff 1 3fe00040
8000 8000 1 40008000
8000 7fff 1 c0010000
ffc0 0005 1 00007ec0
1240 fffd 1 00004940
1234 0000 1 00008000
ffff 0000 1 00008000
0007 0001 1 00008000
0064 0001 1 00008060
ffff 0001 1 00007fe0
0001 ffff 1 0000a080
003f 0003 1 00008000
003f 7fff 1 00176a88
0003 0005 0 0000000f
ffff ffff 0 00000001
8000 8000 0 40000000
1234 fffe 0 ffffdb98

/* xwys_mult.f */
+incdir+logic
logic/xwys_mult_pkg.sv
logic/pp_gen_stage.sv
logic/approx_compress_stage.sv
logic/final_sum_stage.sv
logic/xwys_mult_top.sv
test/xwys_mult_properties.sv
test/xwys_mult_tb.sv
